//--- hdl/free_list.sv
// physical register free list
`timescale 1ns/1ps
`include "rename_settings.svh"

module free_list (
	input  logic                    clock,
	input  logic                    reset,
	prf_alloc_if.free_list          alloc,         // offers out, takes in
	input  logic                    squash,        // mispredict recovery
	input  rename_pkg::prf_mask_t   squash_free,   // tags dropped by the rat
	input  rename_pkg::prf_mask_t   commit_free,   // tags displaced at retire
	output rename_pkg::free_count_t free_count     // number of free tags
);
	import rename_pkg::*;

	prf_mask_t free_q;     // 1 = tag is free
	prf_mask_t free_d;
	prf_mask_t free_rest;  // free bits without the first offer
	prf_tag_t  low1;
	prf_tag_t  low2;

	// priority encoder, lowest set bit wins
	function automatic prf_tag_t lowest_tag(input prf_mask_t mask);
		prf_tag_t tag;
		tag = '0;
		for (int i = `PRF_SIZE - 1; i >= 0; i--) begin
			if (mask[i]) begin
				tag = prf_tag_t'(i);
			end
		end
		return tag;
	endfunction

	//////////////////////////////
	// offers
	//////////////////////////////

	assign low1      = lowest_tag(free_q);
	assign free_rest = free_q & ~(prf_mask_t'(1) << low1);  // knock out first pick
	assign low2      = lowest_tag(free_rest);

	assign alloc.offer_valid1 = |free_q;
	assign alloc.offer_tag1   = low1;
	assign alloc.offer_valid2 = |free_rest;
	assign alloc.offer_tag2   = low2;

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		free_d = free_q;
		if (alloc.take1) begin
			free_d[alloc.offer_tag1] = 1'b0;   // handed to a slot
		end
		if (alloc.take2) begin
			free_d[alloc.offer_tag2] = 1'b0;
		end
		free_d = free_d | commit_free;      // retired displacements
		if (squash) begin
			free_d = free_d | squash_free;  // wrong path tags come back
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// arch regs hold tags 0..ARF_SIZE-1, the rest start free
			free_q <= {{(`PRF_SIZE - `ARF_SIZE){1'b1}}, {`ARF_SIZE{1'b0}}};
		end else begin
			free_q <= free_d;
		end
	end

	//////////////////////////////
	// population count
	//////////////////////////////

	always_comb begin
		free_count = '0;
		for (int i = 0; i < `PRF_SIZE; i++) begin
			free_count = free_count + free_count_t'(free_q[i]);
		end
	end

endmodule

//--- hdl/prf_alloc_if.sv
// physical register allocation link
`timescale 1ns/1ps

interface prf_alloc_if;
	import rename_pkg::*;

	logic     offer_valid1;   // at least one free tag
	prf_tag_t offer_tag1;     // lowest free tag
	logic     offer_valid2;   // at least two free tags
	prf_tag_t offer_tag2;     // second lowest free tag
	logic     take1;          // consume offer one at next edge
	logic     take2;          // consume offer two at next edge

	// free list side, produces offers
	modport free_list (
		output offer_valid1,
		output offer_tag1,
		output offer_valid2,
		output offer_tag2,
		input  take1,
		input  take2
	);

	// map table side, consumes offers
	modport rat (
		input  offer_valid1,
		input  offer_tag1,
		input  offer_valid2,
		input  offer_tag2,
		output take1,
		output take2
	);

endinterface

//--- hdl/rat.sv
// speculative register alias table
`timescale 1ns/1ps
`include "rename_settings.svh"

module rat (
	input  logic                   clock,
	input  logic                   reset,
	prf_alloc_if.rat               alloc,         // free tag offers
	input  logic                   enable1,       // slot one holds an instruction
	input  logic                   enable2,       // slot two holds an instruction
	input  logic                   dest_valid1,   // slot one writes a register
	input  logic                   dest_valid2,
	input  logic                   opa_imm1,      // operand is an immediate
	input  logic                   opb_imm1,
	input  logic                   opa_imm2,
	input  logic                   opb_imm2,
	input  logic                   mispredict,    // restore from rrat
	input  rename_pkg::arch_idx_t  opa_idx1,
	input  rename_pkg::arch_idx_t  opb_idx1,
	input  rename_pkg::arch_idx_t  dest_idx1,
	input  rename_pkg::arch_idx_t  opa_idx2,
	input  rename_pkg::arch_idx_t  opb_idx2,
	input  rename_pkg::arch_idx_t  dest_idx2,
	input  rename_pkg::map_table_t arch_map,      // committed mapping
	output rename_pkg::prf_tag_t   opa_tag1,
	output rename_pkg::prf_tag_t   opb_tag1,
	output rename_pkg::prf_tag_t   dest_tag1,
	output rename_pkg::prf_tag_t   opa_tag2,
	output rename_pkg::prf_tag_t   opb_tag2,
	output rename_pkg::prf_tag_t   dest_tag2,
	output logic                   renamed1,      // slot one got a new tag
	output logic                   renamed2,
	output logic                   halt1,         // slot one must wait
	output logic                   halt2,
	output logic                   squash,        // recovery in progress
	output rename_pkg::prf_mask_t  squash_free    // tags thrown away on recovery
);
	import rename_pkg::*;

	localparam arch_idx_t ZERO_IDX = arch_idx_t'(`ZERO_ARCH);
	localparam prf_tag_t  ZERO_TAG = prf_tag_t'(`ZERO_ARCH);

	map_table_t rat_q;
	map_table_t rat_d;
	logic       need1;         // slot one wants a phys reg
	logic       need2;
	logic       slot2_valid;   // an offer is left for slot two
	prf_tag_t   slot2_tag;

	// plain table read
	function automatic prf_tag_t lookup(input arch_idx_t idx, input logic imm);
		if (imm) begin
			return '0;
		end
		if (idx == ZERO_IDX) begin
			return ZERO_TAG;
		end
		return rat_q[idx];
	endfunction

	// slot two read, sees slot one's fresh destination
	function automatic prf_tag_t bypass(input arch_idx_t idx, input logic imm);
		if (!imm && renamed1 && idx == dest_idx1) begin
			return dest_tag1;
		end
		return lookup(idx, imm);
	endfunction

	//////////////////////////////
	// allocation and halts
	//////////////////////////////

	assign need1 = enable1 & dest_valid1 & (dest_idx1 != ZERO_IDX);
	assign need2 = enable2 & dest_valid2 & (dest_idx2 != ZERO_IDX);

	// slot two gets the second offer only behind a renaming slot one
	assign slot2_valid = need1 ? alloc.offer_valid2 : alloc.offer_valid1;
	assign slot2_tag   = need1 ? alloc.offer_tag2 : alloc.offer_tag1;

	assign halt1 = ~mispredict & need1 & ~alloc.offer_valid1;
	assign halt2 = ~mispredict & ((enable2 & halt1) | (need2 & ~slot2_valid));  // in order

	assign renamed1 = ~mispredict & need1 & alloc.offer_valid1;
	assign renamed2 = ~mispredict & need2 & ~halt2;

	assign alloc.take1 = renamed1 | renamed2;   // first renaming slot
	assign alloc.take2 = renamed1 & renamed2;   // both slots rename

	assign dest_tag1 = renamed1 ? alloc.offer_tag1 : '0;
	assign dest_tag2 = renamed2 ? slot2_tag : '0;

	//////////////////////////////
	// source lookup
	//////////////////////////////

	assign opa_tag1 = mispredict ? '0 : lookup(opa_idx1, opa_imm1);
	assign opb_tag1 = mispredict ? '0 : lookup(opb_idx1, opb_imm1);
	assign opa_tag2 = mispredict ? '0 : bypass(opa_idx2, opa_imm2);
	assign opb_tag2 = mispredict ? '0 : bypass(opb_idx2, opb_imm2);

	//////////////////////////////
	// recovery mask
	//////////////////////////////

	assign squash = mispredict;

	always_comb begin
		squash_free = '0;
		if (mispredict) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				if (rat_q[i] != arch_map[i]) begin
					squash_free[rat_q[i]] = 1'b1;   // only the rat held it
				end
			end
		end
	end

	//////////////////////////////
	// map update
	//////////////////////////////

	always_comb begin
		rat_d = rat_q;
		if (mispredict) begin
			rat_d = arch_map;                  // copy the rrat
		end else begin
			if (renamed1) begin
				rat_d[dest_idx1] = dest_tag1;
			end
			if (renamed2) begin
				rat_d[dest_idx2] = dest_tag2;  // younger slot wins
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				rat_q[i] <= prf_tag_t'(i);     // identity map
			end
		end else begin
			rat_q <= rat_d;
		end
	end

endmodule

//--- hdl/rename_pkg.sv
// rename type package
`include "rename_settings.svh"

package rename_pkg;

	////////////////////////////////
	// register indices
	////////////////////////////////

	typedef logic [$clog2(`ARF_SIZE)-1:0] arch_idx_t;   // arch register number
	typedef logic [$clog2(`PRF_SIZE)-1:0] prf_tag_t;    // physical register tag

	////////////////////////////////
	// wide vectors
	////////////////////////////////

	typedef logic [`PRF_SIZE-1:0] prf_mask_t;           // one bit per phys reg

	// full arch to phys mapping, packed so it moves as one bus
	typedef prf_tag_t [`ARF_SIZE-1:0] map_table_t;

	typedef logic [$clog2(`PRF_SIZE):0] free_count_t;   // 0 .. PRF_SIZE

endpackage

//--- hdl/rename_settings.svh
// rename stage sizes
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// architectural register file
`define ARF_SIZE 32

// physical register file, twice the arf
`define PRF_SIZE 64

// hardwired zero register, never renamed
`define ZERO_ARCH 31

`endif

//--- hdl/rename_stage.sv
// two wide rename stage
`timescale 1ns/1ps

module rename_stage (
	input  logic                    clock,
	input  logic                    reset,
	// slot one, older instruction
	input  logic                    enable1,
	input  logic                    dest_valid1,
	input  logic                    opa_imm1,
	input  logic                    opb_imm1,
	input  rename_pkg::arch_idx_t   opa_idx1,
	input  rename_pkg::arch_idx_t   opb_idx1,
	input  rename_pkg::arch_idx_t   dest_idx1,
	output rename_pkg::prf_tag_t    opa_tag1,
	output rename_pkg::prf_tag_t    opb_tag1,
	output rename_pkg::prf_tag_t    dest_tag1,
	output logic                    renamed1,
	output logic                    halt1,
	// slot two, younger instruction
	input  logic                    enable2,
	input  logic                    dest_valid2,
	input  logic                    opa_imm2,
	input  logic                    opb_imm2,
	input  rename_pkg::arch_idx_t   opa_idx2,
	input  rename_pkg::arch_idx_t   opb_idx2,
	input  rename_pkg::arch_idx_t   dest_idx2,
	output rename_pkg::prf_tag_t    opa_tag2,
	output rename_pkg::prf_tag_t    opb_tag2,
	output rename_pkg::prf_tag_t    dest_tag2,
	output logic                    renamed2,
	output logic                    halt2,
	// retirement and recovery
	input  logic                    commit_valid1,
	input  rename_pkg::arch_idx_t   commit_idx1,
	input  rename_pkg::prf_tag_t    commit_tag1,
	input  logic                    commit_valid2,
	input  rename_pkg::arch_idx_t   commit_idx2,
	input  rename_pkg::prf_tag_t    commit_tag2,
	input  logic                    mispredict,
	output rename_pkg::free_count_t free_count
);
	import rename_pkg::*;

	prf_alloc_if alloc ();    // offer and take handshake

	logic       squash;
	prf_mask_t  squash_free;  // rat to free list on recovery
	prf_mask_t  commit_free;  // rrat to free list on retire
	map_table_t arch_map;     // rrat to rat on recovery

	free_list u_free_list (
		.clock       (clock),
		.reset       (reset),
		.alloc       (alloc),
		.squash      (squash),
		.squash_free (squash_free),
		.commit_free (commit_free),
		.free_count  (free_count)
	);

	rat u_rat (
		.clock (clock), .reset (reset), .alloc (alloc),
		.enable1 (enable1), .enable2 (enable2),
		.dest_valid1 (dest_valid1), .dest_valid2 (dest_valid2),
		.opa_imm1 (opa_imm1), .opb_imm1 (opb_imm1),
		.opa_imm2 (opa_imm2), .opb_imm2 (opb_imm2),
		.mispredict (mispredict),
		.opa_idx1 (opa_idx1), .opb_idx1 (opb_idx1), .dest_idx1 (dest_idx1),
		.opa_idx2 (opa_idx2), .opb_idx2 (opb_idx2), .dest_idx2 (dest_idx2),
		.arch_map (arch_map),
		.opa_tag1 (opa_tag1), .opb_tag1 (opb_tag1), .dest_tag1 (dest_tag1),
		.opa_tag2 (opa_tag2), .opb_tag2 (opb_tag2), .dest_tag2 (dest_tag2),
		.renamed1 (renamed1), .renamed2 (renamed2),
		.halt1 (halt1), .halt2 (halt2),
		.squash (squash), .squash_free (squash_free)
	);

	rrat u_rrat (
		.clock (clock), .reset (reset), .mispredict (mispredict),
		.commit_valid1 (commit_valid1), .commit_valid2 (commit_valid2),
		.commit_idx1 (commit_idx1), .commit_idx2 (commit_idx2),
		.commit_tag1 (commit_tag1), .commit_tag2 (commit_tag2),
		.arch_map (arch_map), .commit_free (commit_free)
	);

endmodule

//--- hdl/rrat.sv
// retirement register alias table
`timescale 1ns/1ps
`include "rename_settings.svh"

module rrat (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   mispredict,     // commits dropped this cycle
	input  logic                   commit_valid1,  // older commit
	input  logic                   commit_valid2,  // younger commit
	input  rename_pkg::arch_idx_t  commit_idx1,
	input  rename_pkg::arch_idx_t  commit_idx2,
	input  rename_pkg::prf_tag_t   commit_tag1,
	input  rename_pkg::prf_tag_t   commit_tag2,
	output rename_pkg::map_table_t arch_map,       // committed state for restore
	output rename_pkg::prf_mask_t  commit_free     // displaced tags
);
	import rename_pkg::*;

	localparam arch_idx_t ZERO_IDX = arch_idx_t'(`ZERO_ARCH);

	map_table_t arch_q;
	map_table_t arch_d;
	logic       do1;     // commit one writes the table
	logic       do2;
	logic       same;    // both commits hit one register

	assign do1  = commit_valid1 & ~mispredict & (commit_idx1 != ZERO_IDX);
	assign do2  = commit_valid2 & ~mispredict & (commit_idx2 != ZERO_IDX);
	assign same = do1 & do2 & (commit_idx1 == commit_idx2);

	always_comb begin
		arch_d = arch_q;
		if (do1) begin
			arch_d[commit_idx1] = commit_tag1;
		end
		if (do2) begin
			arch_d[commit_idx2] = commit_tag2;   // program order, two wins
		end
	end

	always_comb begin
		commit_free = '0;
		if (do1) begin
			commit_free[arch_q[commit_idx1]] = 1'b1;
		end
		if (do2) begin
			// on a shared index commit one's tag is the one displaced
			commit_free[same ? commit_tag1 : arch_q[commit_idx2]] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				arch_q[i] <= prf_tag_t'(i);
			end
		end else begin
			arch_q <= arch_d;
		end
	end

	assign arch_map = arch_q;

endmodule

//--- project.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/prf_alloc_if.sv
hdl/free_list.sv
hdl/rat.sv
hdl/rrat.sv
hdl/rename_stage.sv
sim/rename_assert.sv
sim/rename_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the rename stage testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing --top-module rename_tb -f project.f \
	-o rename_sim > build.log 2>&1 \
	&& ./obj_dir/rename_sim +verilator+error+limit+100000 > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

//--- sim/rename_assert.sv
// rename stage assertions
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_assert (
	input logic clock, reset, mispredict,
	input logic enable1, enable2, dest_valid1, dest_valid2,
	input logic opa_imm1, opb_imm1, opa_imm2, opb_imm2,
	input rename_pkg::arch_idx_t opa_idx1, opb_idx1, dest_idx1,
	input rename_pkg::arch_idx_t opa_idx2, opb_idx2, dest_idx2,
	input rename_pkg::prf_tag_t opa_tag1, opb_tag1, dest_tag1,
	input rename_pkg::prf_tag_t opa_tag2, opb_tag2, dest_tag2,
	input logic renamed1, renamed2, halt1, halt2,
	input logic commit_valid1, commit_valid2,
	input rename_pkg::arch_idx_t commit_idx1, commit_idx2,
	input rename_pkg::prf_tag_t commit_tag1, commit_tag2,
	input rename_pkg::free_count_t free_count
);
	import rename_pkg::*;

	int         fail_count = 0;             // read by the testbench at the end
	prf_tag_t   arch_model [`ARF_SIZE];     // committed mapping
	prf_tag_t   snap [`ARF_SIZE];           // committed mapping at last recovery
	logic       clean;                      // no rename since last recovery
	logic       need1;
	logic       need2;

	assign need1 = enable1 & dest_valid1 & (dest_idx1 != `ZERO_ARCH);
	assign need2 = enable2 & dest_valid2 & (dest_idx2 != `ZERO_ARCH);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				arch_model[i] <= prf_tag_t'(i);   // identity after reset
				snap[i]       <= prf_tag_t'(i);
			end
			clean <= 1'b1;
		end else if (mispredict) begin
			snap  <= arch_model;                  // commits ignored this cycle
			clean <= 1'b1;
		end else begin
			if (commit_valid1 && commit_idx1 != `ZERO_ARCH) begin
				arch_model[commit_idx1] <= commit_tag1;
			end
			if (commit_valid2 && commit_idx2 != `ZERO_ARCH) begin
				arch_model[commit_idx2] <= commit_tag2;   // younger wins
			end
			if (renamed1 || renamed2) begin
				clean <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// reset and allocation
	//////////////////////////////

	a_reset: assert property (@(posedge clock) $past(reset) && !reset |->
		!renamed1 && !renamed2 && !halt1 && !halt2 && free_count == 32)
		else begin
			$error("error %0t: bad state after reset", $time);
			fail_count++;
		end

	a_distinct: assert property (@(posedge clock) disable iff (reset)
		renamed1 && renamed2 |-> dest_tag1 != dest_tag2)
		else begin
			$error("error %0t: both slots got one tag", $time);
			fail_count++;
		end

	a_count: assert property (@(posedge clock) disable iff (reset)
		renamed1 && renamed2 && !commit_valid1 && !commit_valid2
		|=> free_count == $past(free_count) - 2)
		else begin
			$error("error %0t: free_count did not fall by two", $time);
			fail_count++;
		end

	//////////////////////////////
	// source lookup
	//////////////////////////////

	a_byp_a: assert property (@(posedge clock) disable iff (reset)
		renamed1 && !opa_imm2 && opa_idx2 == dest_idx1 |-> opa_tag2 == dest_tag1)
		else begin
			$error("error %0t: opa bypass wrong", $time);
			fail_count++;
		end

	a_byp_b: assert property (@(posedge clock) disable iff (reset)
		renamed1 && !opb_imm2 && opb_idx2 == dest_idx1 |-> opb_tag2 == dest_tag1)
		else begin
			$error("error %0t: opb bypass wrong", $time);
			fail_count++;
		end

	a_last2: assert property (@(posedge clock) disable iff (reset)
		!mispredict && !opa_imm1 && $past(renamed2) && opa_idx1 == $past(dest_idx2)
		|-> opa_tag1 == $past(dest_tag2))
		else begin
			$error("error %0t: stale tag after slot two rename", $time);
			fail_count++;
		end

	a_last1: assert property (@(posedge clock) disable iff (reset)
		!mispredict && !opb_imm1 && $past(renamed1) && opb_idx1 == $past(dest_idx1)
		&& !($past(renamed2) && $past(dest_idx2) == $past(dest_idx1))
		|-> opb_tag1 == $past(dest_tag1))
		else begin
			$error("error %0t: stale tag after slot one rename", $time);
			fail_count++;
		end

	a_imm: assert property (@(posedge clock) disable iff (reset)
		!mispredict && opa_imm1 |-> opa_tag1 == 0)
		else begin
			$error("error %0t: immediate not tag 0", $time);
			fail_count++;
		end

	a_zero: assert property (@(posedge clock) disable iff (reset)
		!mispredict && !opb_imm1 && opb_idx1 == `ZERO_ARCH |-> opb_tag1 == `ZERO_ARCH)
		else begin
			$error("error %0t: zero register not tag 31", $time);
			fail_count++;
		end

	//////////////////////////////
	// halts and recovery
	//////////////////////////////

	a_halt1: assert property (@(posedge clock) disable iff (reset)
		halt1 == (!mispredict && need1 && free_count == 0))
		else begin
			$error("error %0t: halt1 wrong", $time);
			fail_count++;
		end

	a_halt2: assert property (@(posedge clock) disable iff (reset)
		halt2 == (!mispredict && ((enable2 && halt1)
		|| (need2 && free_count < (need1 ? 2 : 1)))))
		else begin
			$error("error %0t: halt2 wrong", $time);
			fail_count++;
		end

	a_squash: assert property (@(posedge clock) disable iff (reset)
		mispredict |-> !renamed1 && !renamed2)
		else begin
			$error("error %0t: rename during mispredict", $time);
			fail_count++;
		end

	a_restore: assert property (@(posedge clock) disable iff (reset)
		clean && !mispredict && !opa_imm1 && opa_idx1 != `ZERO_ARCH
		|-> opa_tag1 == snap[opa_idx1])
		else begin
			$error("error %0t: restored map wrong on opa", $time);
			fail_count++;
		end

	a_restore_b: assert property (@(posedge clock) disable iff (reset)
		clean && !mispredict && !opb_imm1 && opb_idx1 != `ZERO_ARCH
		|-> opb_tag1 == snap[opb_idx1])
		else begin
			$error("error %0t: restored map wrong on opb", $time);
			fail_count++;
		end

endmodule

bind rename_stage rename_assert u_assert (.*);

//--- sim/rename_tb.sv
// rename stage testbench
`timescale 1ns/1ps

module rename_tb;
	import rename_pkg::*;

	logic clock, reset, mispredict;
	logic enable1, enable2, dest_valid1, dest_valid2;
	logic opa_imm1, opb_imm1, opa_imm2, opb_imm2;
	arch_idx_t opa_idx1, opb_idx1, dest_idx1, opa_idx2, opb_idx2, dest_idx2;
	prf_tag_t opa_tag1, opb_tag1, dest_tag1, opa_tag2, opb_tag2, dest_tag2;
	logic renamed1, renamed2, halt1, halt2;
	logic commit_valid1, commit_valid2;
	arch_idx_t commit_idx1, commit_idx2;
	prf_tag_t commit_tag1, commit_tag2;
	free_count_t free_count;

	logic [31:0] lfsr_state;
	logic [10:0] alloc_q [$];     // {arch idx, tag} in program order
	int          timeouts;
	int          errors;

	rename_stage u_dut (.*);

	always #50 clock = ~clock;

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = next_lfsr(lfsr_state);   // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task clear_inputs;
		{enable1, enable2, dest_valid1, dest_valid2, mispredict} = '0;
		{opa_imm1, opb_imm1, opa_imm2, opb_imm2} = '0;
		{opa_idx1, opb_idx1, dest_idx1, opa_idx2, opb_idx2, dest_idx2} = '0;
		{commit_valid1, commit_valid2, commit_idx1, commit_idx2} = '0;
		{commit_tag1, commit_tag2} = '0;
	endtask

	task record_renames;
		#20;                                          // outputs settled
		if (renamed1) begin
			alloc_q.push_back({dest_idx1, dest_tag1});
		end
		if (renamed2) begin
			alloc_q.push_back({dest_idx2, dest_tag2});
		end
	endtask

	////////////////////////////////
	// stimulus phases
	////////////////////////////////

	task random_rename_until_halt;
		int   waited;
		logic stop;
		waited = 0;
		stop = 1'b0;
		while (!stop && waited < 500) begin
			@(negedge clock);
			clear_inputs();
			enable1 = (random_bits(2) != 0);
			enable2 = (random_bits(2) != 0);
			dest_valid1 = (random_bits(3) != 0);
			dest_valid2 = (random_bits(3) != 0);
			dest_idx1 = arch_idx_t'(random_bits(5));
			dest_idx2 = arch_idx_t'(random_bits(5));
			opa_idx1 = arch_idx_t'(random_bits(5));
			opb_idx1 = arch_idx_t'(random_bits(5));
			opa_imm1 = (random_bits(3) == 0);
			opb_imm1 = (random_bits(3) == 0);
			opa_idx2 = random_bits(1) ? dest_idx1 : arch_idx_t'(random_bits(5));  // bypass bait
			opb_idx2 = random_bits(1) ? dest_idx1 : arch_idx_t'(random_bits(5));
			opa_imm2 = (random_bits(3) == 0);
			opb_imm2 = (random_bits(3) == 0);
			record_renames();
			stop = halt1 | halt2;
			waited++;
		end
		if (!stop) begin
			$display("timeout: no halt seen during random renames");
			timeouts++;
		end
	endtask

	task directed_renames;    // distinct dests let recovery free them all
		for (int i = 0; i < 3; i++) begin
			@(negedge clock);
			clear_inputs();
			{enable1, enable2, dest_valid1, dest_valid2} = 4'hf;
			dest_idx1 = arch_idx_t'(2 * i);
			dest_idx2 = arch_idx_t'(2 * i + 1);
			opa_idx2 = dest_idx1;
			if (i > 0) begin
				opa_idx1 = arch_idx_t'(2 * i - 1);   // slot two dest of last cycle
				opb_idx1 = arch_idx_t'(2 * i - 2);   // slot one dest of last cycle
			end else begin
				opa_imm1 = 1'b1;
			end
			record_renames();
		end
	endtask

	task commit_entries(input int count);
		logic [10:0] e;
		int          left;
		left = count;
		while (left > 0 && alloc_q.size() > 0) begin
			@(negedge clock);
			clear_inputs();
			e = alloc_q.pop_front();
			{commit_valid1, commit_idx1, commit_tag1} = {1'b1, e};
			left--;
			if (left > 0 && alloc_q.size() > 0) begin
				e = alloc_q.pop_front();
				{commit_valid2, commit_idx2, commit_tag2} = {1'b1, e};
				left--;
			end
		end
		@(negedge clock);
		clear_inputs();
	endtask

	task mispredict_and_sweep;
		@(negedge clock);
		clear_inputs();
		mispredict = 1'b1;
		{enable1, enable2, dest_valid1, dest_valid2} = 4'hf;   // would rename if not squashed
		dest_idx1 = arch_idx_t'(1);
		dest_idx2 = arch_idx_t'(2);
		commit_valid1 = 1'b1;                                  // dropped by the rrat
		commit_idx1 = arch_idx_t'(3);
		commit_tag1 = prf_tag_t'(40);
		for (int i = 0; i < 16; i++) begin       // read back every register
			@(negedge clock);
			clear_inputs();
			opa_idx1 = arch_idx_t'(2 * i);
			opb_idx1 = arch_idx_t'(2 * i + 1);
		end
		@(negedge clock);
		clear_inputs();
	endtask

	task wait_free_count(input int target, input string what);
		int waited;
		waited = 0;
		while (free_count != free_count_t'(target) && waited < 100) begin
			@(negedge clock);
			waited++;
		end
		if (free_count != free_count_t'(target)) begin
			$display("timeout: free_count stuck at %0d after %s", free_count, what);
			timeouts++;
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		lfsr_state = 32'hc9df;
		timeouts = 0;
		clear_inputs();
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		random_rename_until_halt();
		commit_entries(alloc_q.size());
		wait_free_count(32, "commits");
		mispredict_and_sweep();

		directed_renames();
		commit_entries(3);
		alloc_q.delete();                          // the rest stays speculative
		mispredict_and_sweep();
		wait_free_count(32, "recovery");

		repeat (2) @(negedge clock);
		errors = u_dut.u_assert.fail_count;
		$display("assertion errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
